/* verilog/fix_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// shared types and constants of the FIX session engine
// sequence numbers and tag values hold at most three digits (999)
// msg type decoding looks at single-character MsgType values only
// ~~~~~~~~~~~~~~~~~~~~
package fix_pkg;

	typedef logic [7:0]  fix_byte_t;	// one stream byte
	typedef logic [13:0] fix_tag_t;		// decimal tag number
	typedef logic [9:0]  fix_seq_t;		// sequence number, up to 999
	typedef logic [7:0]  fix_sum_t;		// checksum mod 256
	typedef logic [2:0]  fix_credit_t;	// output credits

	typedef enum logic [2:0] {
		MSG_HEARTBEAT,				// '0'
		MSG_TEST_REQ,				// '1'
		MSG_LOGOUT,				// '5'
		MSG_LOGON,				// 'A'
		MSG_OTHER
	} fix_msg_t;

	localparam fix_byte_t   SOH          = 8'h01;
	localparam fix_tag_t    TAG_MSG_TYPE = 14'd35;
	localparam fix_tag_t    TAG_SEQ_NUM  = 14'd34;
	localparam fix_tag_t    TAG_CHECKSUM = 14'd10;
	localparam fix_credit_t OUT_CREDITS  = 3'd4;
	localparam int          REPLY_BYTES  = 19;

	// MsgType character to enum
	function automatic fix_msg_t msg_from_char(input fix_byte_t c);
		case (c)
			8'h30:   return MSG_HEARTBEAT;
			8'h31:   return MSG_TEST_REQ;
			8'h35:   return MSG_LOGOUT;
			8'h41:   return MSG_LOGON;
			default: return MSG_OTHER;
		endcase
	endfunction

	function automatic fix_byte_t msg_to_char(input fix_msg_t t);
		case (t)
			MSG_HEARTBEAT: return 8'h30;
			MSG_TEST_REQ:  return 8'h31;
			MSG_LOGOUT:    return 8'h35;
			MSG_LOGON:     return 8'h41;
			default:       return 8'h3f;	// '?' never sent
		endcase
	endfunction

endpackage

/* verilog/fix_parser.sv */
// ~~~~~~~~~~~~~~~~~~~~
// tag=value decoder for the incoming FIX stream, no back-pressure
// values longer than three digits wrap and give wrong results
// the summary is valid for one cycle after the SOH closing tag 10
// ~~~~~~~~~~~~~~~~~~~~
module fix_parser (
	input  logic               clk,
	input  logic               rst_n_i,
	input  fix_pkg::fix_byte_t in_byte_i,
	input  logic               in_valid_i,
	output logic               msg_done_o,
	output fix_pkg::fix_msg_t  msg_type_o,
	output fix_pkg::fix_seq_t  msg_seq_o,
	output logic               msg_chk_ok_o
);
	import fix_pkg::*;

	typedef enum logic {TAG, VALUE} state_t;

	state_t   state_q;
	fix_tag_t tag_q;		// tag being built or in use
	fix_seq_t val_q;		// decimal value of the field
	logic     first_q;		// next byte is the first of the value
	fix_sum_t sum_q;		// all bytes of the message so far
	fix_sum_t mark_q;		// sum up to the last closed field
	logic     is_digit;
	logic     is_soh;

	assign is_digit = (in_byte_i >= 8'h30) && (in_byte_i <= 8'h39);
	assign is_soh   = (in_byte_i == SOH);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q      <= TAG;
			tag_q        <= '0;
			val_q        <= '0;
			first_q      <= 1'b0;
			sum_q        <= '0;
			mark_q       <= '0;
			msg_done_o   <= 1'b0;
			msg_type_o   <= MSG_OTHER;
			msg_seq_o    <= '0;
			msg_chk_ok_o <= 1'b0;
		end else begin
			msg_done_o <= 1'b0;
			if (in_valid_i) begin
				sum_q <= sum_q + in_byte_i;
				case (state_q)
					TAG: begin
						if (in_byte_i == 8'h3d) begin	// '='
							state_q <= VALUE;
							val_q   <= '0;
							first_q <= 1'b1;
						end else if (is_digit) begin
							tag_q <= tag_q * 14'd10 + {10'd0, in_byte_i[3:0]};
						end else if (is_soh) begin	// stray separator
							tag_q  <= '0;
							mark_q <= sum_q + in_byte_i;
						end
					end
					VALUE: begin
						first_q <= 1'b0;
						if (is_soh) begin
							state_q <= TAG;
							tag_q   <= '0;
							mark_q  <= sum_q + in_byte_i;
							if (tag_q == TAG_SEQ_NUM)
								msg_seq_o <= val_q;
							if (tag_q == TAG_CHECKSUM) begin
								// mark_q excludes the "10=" field itself
								msg_done_o   <= 1'b1;
								msg_chk_ok_o <= (val_q == {2'b00, mark_q});
								sum_q        <= '0;
								mark_q       <= '0;
							end
						end else begin
							if (tag_q == TAG_MSG_TYPE)
								msg_type_o <= first_q ? msg_from_char(in_byte_i)
								                      : MSG_OTHER;	// multi-char type
							if (is_digit)
								val_q <= val_q * 10'd10 + {6'd0, in_byte_i[3:0]};
						end
					end
					default: state_q <= TAG;
				endcase
			end
		end
	end

endmodule

/* verilog/session_manager.sv */
// ~~~~~~~~~~~~~~~~~~~~
// session FSM with expected and outgoing sequence numbers
// a decision made while a reply still waits is dropped
// outgoing sequence wraps past 1023, keep sessions under 999 replies
// ~~~~~~~~~~~~~~~~~~~~
module session_manager (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              msg_done_i,
	input  fix_pkg::fix_msg_t msg_type_i,
	input  fix_pkg::fix_seq_t msg_seq_i,
	input  logic              msg_chk_ok_i,
	input  logic              reply_ready_i,
	output logic              reply_valid_o,
	output fix_pkg::fix_msg_t reply_type_o,
	output fix_pkg::fix_seq_t reply_seq_o
);
	import fix_pkg::*;

	typedef enum logic {IDLE, ACTIVE} state_t;

	state_t   state_q, state_d;
	fix_seq_t exp_q, exp_d;		// expected incoming seq
	fix_seq_t out_seq_q;		// next outgoing seq
	logic     want_reply;
	fix_msg_t want_type;
	logic     handshake;

	assign handshake   = reply_valid_o && reply_ready_i;
	assign reply_seq_o = out_seq_q;

	always_comb begin
		state_d    = state_q;
		exp_d      = exp_q;
		want_reply = 1'b0;
		want_type  = MSG_LOGOUT;
		if (msg_done_i && msg_chk_ok_i) begin	// bad checksum ignored
			case (state_q)
				IDLE: begin
					if (msg_type_i == MSG_LOGON && msg_seq_i == 10'd1) begin
						state_d    = ACTIVE;
						exp_d      = 10'd2;
						want_reply = 1'b1;
						want_type  = MSG_LOGON;
					end
				end
				ACTIVE: begin
					if (msg_seq_i != exp_q) begin	// gap, close the session
						state_d    = IDLE;
						want_reply = 1'b1;
					end else begin
						exp_d = exp_q + 10'd1;
						if (msg_type_i == MSG_TEST_REQ) begin
							want_reply = 1'b1;
							want_type  = MSG_HEARTBEAT;
						end else if (msg_type_i == MSG_LOGOUT) begin
							state_d    = IDLE;
							want_reply = 1'b1;
						end
					end
				end
				default: state_d = IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q       <= IDLE;
			exp_q         <= 10'd1;
			out_seq_q     <= 10'd1;
			reply_valid_o <= 1'b0;
			reply_type_o  <= MSG_HEARTBEAT;
		end else begin
			state_q <= state_d;
			exp_q   <= exp_d;
			if (handshake) begin
				out_seq_q     <= out_seq_q + 10'd1;
				reply_valid_o <= 1'b0;
			end
			if (want_reply && (!reply_valid_o || handshake)) begin
				reply_valid_o <= 1'b1;
				reply_type_o  <= want_type;
			end
		end
	end

endmodule

/* verilog/message_builder.sv */
// ~~~~~~~~~~~~~~~~~~~~
// serializes a 19 byte reply with tags 35, 34 and 10
// every byte needs a credit, one credit returns per taken byte
// ~~~~~~~~~~~~~~~~~~~~
module message_builder (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               reply_valid_i,
	input  fix_pkg::fix_msg_t  reply_type_i,
	input  fix_pkg::fix_seq_t  reply_seq_i,
	output logic               reply_ready_o,
	input  logic               out_credit_i,
	output fix_pkg::fix_byte_t out_byte_o,
	output logic               out_valid_o,
	output logic               msg_end_o
);
	import fix_pkg::*;

	logic        busy_q;
	logic [4:0]  idx_q;		// byte index 0..18
	fix_sum_t    sum_q;		// over bytes 0..11
	fix_credit_t credit_q;
	fix_byte_t   type_chr_q;
	fix_byte_t   seq_h_q, seq_t_q, seq_u_q;	// ascii seq digits
	fix_seq_t    seq_h, seq_t, seq_u;
	fix_sum_t    chk_h, chk_t, chk_u;
	fix_byte_t   cur_byte;
	logic        send;

	function automatic fix_byte_t ascii_digit(input logic [3:0] d);
		return {4'h3, d};
	endfunction

	assign reply_ready_o = !busy_q;
	assign send          = busy_q && (credit_q != '0);

	assign seq_h = reply_seq_i / 10'd100;
	assign seq_t = (reply_seq_i / 10'd10) % 10'd10;
	assign seq_u = reply_seq_i % 10'd10;

	assign chk_h = sum_q / 8'd100;
	assign chk_t = (sum_q / 8'd10) % 8'd10;
	assign chk_u = sum_q % 8'd10;

	always_comb begin
		case (idx_q)
			5'd0, 5'd5:   cur_byte = 8'h33;	// '3'
			5'd1:         cur_byte = 8'h35;	// '5'
			5'd6:         cur_byte = 8'h34;	// '4'
			5'd2, 5'd7,
			5'd14:        cur_byte = 8'h3d;	// '='
			5'd3:         cur_byte = type_chr_q;
			5'd8:         cur_byte = seq_h_q;
			5'd9:         cur_byte = seq_t_q;
			5'd10:        cur_byte = seq_u_q;
			5'd12:        cur_byte = 8'h31;	// '1'
			5'd13:        cur_byte = 8'h30;	// '0'
			5'd15:        cur_byte = ascii_digit(chk_h[3:0]);
			5'd16:        cur_byte = ascii_digit(chk_t[3:0]);
			5'd17:        cur_byte = ascii_digit(chk_u[3:0]);
			default:      cur_byte = SOH;	// 4, 11, 18
		endcase
	end

	// request payload and output byte
	always_ff @(posedge clk) begin
		if (reply_valid_i && reply_ready_o) begin
			type_chr_q <= msg_to_char(reply_type_i);
			seq_h_q    <= ascii_digit(seq_h[3:0]);
			seq_t_q    <= ascii_digit(seq_t[3:0]);
			seq_u_q    <= ascii_digit(seq_u[3:0]);
		end
		if (send)
			out_byte_o <= cur_byte;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			busy_q      <= 1'b0;
			idx_q       <= '0;
			sum_q       <= '0;
			credit_q    <= OUT_CREDITS;
			out_valid_o <= 1'b0;
			msg_end_o   <= 1'b0;
		end else begin
			case ({send, out_credit_i})
				2'b10:   credit_q <= credit_q - 3'd1;
				2'b01:   credit_q <= credit_q + 3'd1;
				default: credit_q <= credit_q;	// both or neither
			endcase
			out_valid_o <= send;
			msg_end_o   <= send && (idx_q == 5'(REPLY_BYTES - 1));
			if (reply_valid_i && reply_ready_o) begin
				busy_q <= 1'b1;
				idx_q  <= '0;
				sum_q  <= '0;
			end else if (send) begin
				if (idx_q < 5'd12)
					sum_q <= sum_q + cur_byte;
				if (idx_q == 5'(REPLY_BYTES - 1)) begin
					busy_q <= 1'b0;
					idx_q  <= '0;
				end else begin
					idx_q <= idx_q + 5'd1;
				end
			end
		end
	end

endmodule

/* verilog/fix_engine.sv */
// ~~~~~~~~~~~~~~~~~~~~
// top of the FIX session engine
// input has no back-pressure, output runs on credits
// ~~~~~~~~~~~~~~~~~~~~
module fix_engine (
	input  logic               clk,
	input  logic               rst_n_i,
	input  fix_pkg::fix_byte_t in_byte_i,
	input  logic               in_valid_i,
	input  logic               out_credit_i,
	output fix_pkg::fix_byte_t out_byte_o,
	output logic               out_valid_o,
	output logic               msg_end_o
);
	import fix_pkg::*;

	logic     msg_done;
	fix_msg_t msg_type;
	fix_seq_t msg_seq;
	logic     msg_chk_ok;
	logic     reply_valid;
	logic     reply_ready;
	fix_msg_t reply_type;
	fix_seq_t reply_seq;

	fix_parser i_parser (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.in_byte_i    (in_byte_i),
		.in_valid_i   (in_valid_i),
		.msg_done_o   (msg_done),	// to session fsm
		.msg_type_o   (msg_type),
		.msg_seq_o    (msg_seq),
		.msg_chk_ok_o (msg_chk_ok)
	);

	session_manager i_session (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.msg_done_i    (msg_done),
		.msg_type_i    (msg_type),
		.msg_seq_i     (msg_seq),
		.msg_chk_ok_i  (msg_chk_ok),
		.reply_ready_i (reply_ready),
		.reply_valid_o (reply_valid),	// to builder
		.reply_type_o  (reply_type),
		.reply_seq_o   (reply_seq)
	);

	message_builder i_builder (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.reply_valid_i (reply_valid),
		.reply_type_i  (reply_type),
		.reply_seq_i   (reply_seq),
		.reply_ready_o (reply_ready),
		.out_credit_i  (out_credit_i),
		.out_byte_o    (out_byte_o),
		.out_valid_o   (out_valid_o),
		.msg_end_o     (msg_end_o)
	);

endmodule

/* bench/fix_engine_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// messages and expected replies come from bench/fix_golden.txt
// run from the project root so that the golden file path resolves
// a message is sent only after the previous reply has ended
// ~~~~~~~~~~~~~~~~~~~~
module fix_engine_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import fix_pkg::*;

	logic        clk;
	logic        rst_n_i;
	fix_byte_t   in_byte_i;
	logic        in_valid_i;
	logic        out_credit_i;
	fix_byte_t   out_byte_o;
	logic        out_valid_o;
	logic        msg_end_o;

	string       msg_lines[$];		// S lines with '|' for SOH
	string       reply_lines[$];		// matching R lines
	fix_byte_t   exp_bytes[$];		// reply bytes still to come
	int          credit_due[$];		// step of each pending credit pulse
	int          n_lines = 0;
	int          step = 0;
	int          taken = 0;		// bytes seen on the output
	int          returned = 0;		// credit pulses given back
	int          value_errs = 0;
	int          other_errs = 0;
	logic [31:0] rng_state = 32'hdb9d719d;

	fix_engine i_dut (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.in_byte_i    (in_byte_i),
		.in_valid_i   (in_valid_i),
		.out_credit_i (out_credit_i),
		.out_byte_o   (out_byte_o),
		.out_valid_o  (out_valid_o),
		.msg_end_o    (msg_end_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic fix_byte_t to_ascii(input int d);
		return fix_byte_t'(48 + d);
	endfunction

	function automatic string trim_line(input string s);
		int n;
		n = s.len();
		while (n > 0 && s[n-1] <= 8'h20)
			n--;
		return s.substr(0, n - 1);
	endfunction

	// decimal number after "R x "
	function automatic int parse_seq(input string s);
		int v;
		v = 0;
		for (int i = 4; i < s.len(); i++) begin
			if (s[i] >= "0" && s[i] <= "9")
				v = v * 10 + int'(s[i]) - 48;
		end
		return v;
	endfunction

	task automatic check_byte(input fix_byte_t got, input fix_byte_t exp);
		if (got !== exp) begin
			$display("Error at %0d ns: reply byte 0x%02h, expected 0x%02h", $time, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_end(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0d ns: msg_end_o is %b, expected %b", $time, got, exp);
			value_errs++;
		end
	endtask

	task automatic load_golden();
		int    fd;
		string line;
		fd = $fopen("bench/fix_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open bench/fix_golden.txt");
			other_errs++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				line = trim_line(line);
				if (line.len() > 2 && line[0] == "S") begin
					msg_lines.push_back(line.substr(2, line.len() - 1));
					n_lines++;
				end else if (line.len() > 2 && line[0] == "R") begin
					reply_lines.push_back(line);
					n_lines++;
				end
			end
			$fclose(fd);
		end
		if (msg_lines.size() == 0 || msg_lines.size() != reply_lines.size()) begin
			$display("Golden file holds %0d messages but %0d reply lines",
			         msg_lines.size(), reply_lines.size());
			other_errs++;
		end
	endtask

	// expected 19 reply bytes with the checksum over the first 12
	task automatic expect_reply(input fix_byte_t type_chr, input int seq);
		fix_byte_t head[12];
		fix_sum_t  sum;
		head = '{8'h33, 8'h35, 8'h3d, type_chr, SOH, 8'h33, 8'h34, 8'h3d,
		         to_ascii(seq / 100), to_ascii((seq / 10) % 10), to_ascii(seq % 10), SOH};
		sum = '0;
		foreach (head[i]) begin
			exp_bytes.push_back(head[i]);
			sum = sum + head[i];
		end
		exp_bytes.push_back(8'h31);
		exp_bytes.push_back(8'h30);
		exp_bytes.push_back(8'h3d);
		exp_bytes.push_back(to_ascii(int'(sum) / 100));
		exp_bytes.push_back(to_ascii((int'(sum) / 10) % 10));
		exp_bytes.push_back(to_ascii(int'(sum) % 10));
		exp_bytes.push_back(SOH);
	endtask

	task automatic send_message(input string m);
		for (int i = 0; i < m.len(); i++) begin
			@(posedge clk);
			#2;
			in_byte_i  = (m[i] == "|") ? SOH : m[i];
			in_valid_i = 1'b1;
		end
		@(posedge clk);
		#2;
		in_valid_i = 1'b0;
		in_byte_i  = '0;
	endtask

	task automatic wait_reply_end();
		do begin
			@(posedge clk);
			#2;
		end while (msg_end_o !== 1'b1);
		#1;	// receiver model takes the last byte first
		if (exp_bytes.size() != 0) begin
			$display("Reply ended with %0d expected bytes missing", exp_bytes.size());
			other_errs++;
			exp_bytes.delete();
		end
	endtask

	// receiver model that checks bytes and returns credits after 0 to 7 cycles
	task automatic credit_and_check();
		int due;
		forever begin
			@(posedge clk);
			#2;
			out_credit_i = 1'b0;
			if (out_valid_o === 1'b1) begin
				taken++;
				if (exp_bytes.size() == 0) begin
					$display("Unexpected reply byte 0x%02h at %0d ns", out_byte_o, $time);
					other_errs++;
				end else begin
					check_end(msg_end_o, exp_bytes.size() == 1);
					check_byte(out_byte_o, exp_bytes.pop_front());
				end
				rng_state = xorshift32(rng_state);
				due = step + int'(rng_state[2:0]);
				if (credit_due.size() > 0 && due <= credit_due[$])
					due = credit_due[$] + 1;	// one pulse per cycle
				credit_due.push_back(due);
			end
			if (taken - returned > int'(OUT_CREDITS)) begin
				$display("Too many bytes outstanding at %0d ns: %0d without credit",
				         $time, taken - returned);
				other_errs++;
			end
			if (credit_due.size() > 0 && credit_due[0] <= step) begin
				void'(credit_due.pop_front());
				out_credit_i = 1'b1;
				returned++;
			end
			step++;
		end
	endtask

	initial begin : main_seq
		string r;
		rst_n_i      = 1'b0;
		in_byte_i    = '0;
		in_valid_i   = 1'b0;
		out_credit_i = 1'b0;
		load_golden();
		repeat (3) @(posedge clk);
		#2;
		rst_n_i = 1'b1;
		fork
			credit_and_check();
		join_none
		if (other_errs == 0) begin
			for (int k = 0; k < msg_lines.size(); k++) begin
				r = reply_lines[k];
				if (r[2] != "-")
					expect_reply(r[2], parse_seq(r));
				send_message(msg_lines[k]);
				if (r[2] == "-")
					repeat (40) @(posedge clk);	// no byte may show up here
				else
					wait_reply_end();
				repeat (2) @(posedge clk);
			end
		end
		$display("Checks done: %0d value errors, %0d other errors", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin : watchdog
		wait (n_lines > 0);
		#(n_lines * 2000);
		$display("Timeout: the run did not finish within %0d ns", n_lines * 2000);
		$display("Some tests failed");
		$finish;
	end

endmodule

/* bench/fix_golden.txt */
# S <message with | for SOH>, tag 10 correct unless noted
# R <type char> <outgoing seq>, or R - when no reply is expected
S 35=A|34=1|10=189|
R A 001
S 35=1|34=2|10=174|
R 0 002
S 35=0|34=3|10=174|
R -
S 35=1|34=4|10=000|
R -
S 35=1|34=4|10=176|
R 0 003
S 35=D|34=5|10=196|
R -
S 35=1|34=9|10=181|
R 5 004
S 35=1|34=10|10=221|
R -
S 35=A|34=1|10=189|
R A 005
S 35=1|34=2|10=174|
R 0 006
S 35=5|34=3|10=179|
R 5 007
S 35=1|34=4|10=176|
R -

/* sources.f */
verilog/fix_pkg.sv
verilog/fix_parser.sv
verilog/session_manager.sv
verilog/message_builder.sv
verilog/fix_engine.sv
bench/fix_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the FIX engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f sources.f \
	--top-module fix_engine_tb --Mdir obj_dir -o fix_engine_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/fix_engine_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
	exit 0
fi
exit 1
